/* source/uart_dbg_pkg.sv */
package uart_dbg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Timing and sizes
  //////////////////////////////////////////////////////////////////////

  // Clock cycles per UART bit
  localparam int unsigned ClksPerBit = 16;
  localparam int unsigned MemDepth   = 256;
  // Bytes in an address or length field
  localparam int unsigned HdrBytes   = 8;

  typedef logic [7:0]                  byte_t;
  typedef logic [63:0]                 dbg_addr_t;
  typedef logic [63:0]                 dbg_len_t;
  typedef logic [$clog2(MemDepth)-1:0] mem_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Protocol bytes
  //////////////////////////////////////////////////////////////////////

  localparam byte_t CmdRead  = 8'h11;
  localparam byte_t CmdWrite = 8'h12;
  localparam byte_t CmdExec  = 8'h13;
  localparam byte_t DbgAck   = 8'h06;
  localparam byte_t DbgEot   = 8'h04;

  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_byte_t;

  typedef struct packed {
    logic  valid;
    byte_t data;
  } tx_byte_t;

  typedef struct packed {
    logic      valid;
    logic      we;
    mem_addr_t addr;
    byte_t     wdata;
  } mem_req_t;

  typedef enum logic [3:0] {
    Idle, RdAddr, RdLen, ExAddr, Ack, WrData, RdFetch, RdSend, Eot
  } dbg_state_e;

endpackage

/* source/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   rx_i,
  output uart_dbg_pkg::rx_byte_t rx_byte_o
);

  // Two sync flops, the third one only for the start edge
  logic [2:0]                                  rx_sync_q;
  logic                                        rx_s;
  logic                                        busy_q;
  logic [$clog2(uart_dbg_pkg::ClksPerBit)-1:0] cnt_q;
  // 0 is the start bit, 1 to 8 data, 9 the stop bit
  logic [3:0]                                  bit_q;
  logic                                        sample;
  uart_dbg_pkg::byte_t                         shift_q;

  assign rx_s   = rx_sync_q[1];
  assign sample = busy_q && (cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_sync_q <= '1;
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      bit_q     <= '0;
    end else begin
      rx_sync_q <= {rx_sync_q[1:0], rx_i};
      if (!busy_q) begin
        if (rx_sync_q[2] && !rx_s) begin
          busy_q <= 1'b1;
          // First sample lands in the middle of the start bit
          cnt_q  <= $bits(cnt_q)'(uart_dbg_pkg::ClksPerBit / 2 - 1);
          bit_q  <= '0;
        end
      end else if (sample) begin
        cnt_q <= $bits(cnt_q)'(uart_dbg_pkg::ClksPerBit - 1);
        bit_q <= bit_q + 1'b1;
        // Glitch on the line or frame done
        if ((bit_q == 4'd0 && rx_s) || bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (sample && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte_o.valid = sample && (bit_q == 4'd9) && rx_s;
  assign rx_byte_o.data  = shift_q;

  assert property (@(posedge clk) disable iff (!rst_n_i)
    rx_byte_o.valid |=> !rx_byte_o.valid)
    else $error("rx byte strobe high for two cycles");

endmodule

/* source/dbg_cmd_fsm.sv */
`timescale 1ns/1ns

module dbg_cmd_fsm (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  uart_dbg_pkg::rx_byte_t  rx_byte_i,
  output uart_dbg_pkg::mem_req_t  mem_req_o,
  input  uart_dbg_pkg::byte_t     mem_rdata_i,
  output uart_dbg_pkg::tx_byte_t  tx_byte_o,
  input  logic                    tx_ready_i,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o
);

  uart_dbg_pkg::dbg_state_e                  state_q, state_d;
  uart_dbg_pkg::byte_t                       cmd_q;
  logic [$clog2(uart_dbg_pkg::HdrBytes)-1:0] hdr_cnt_q;
  logic                                      hdr_last;
  logic                                      wr_pend_q;
  uart_dbg_pkg::dbg_addr_t                   addr_q;
  uart_dbg_pkg::dbg_len_t                    len_q;
  logic                                      len_last;
  uart_dbg_pkg::mem_addr_t                   idx_q;
  uart_dbg_pkg::byte_t                       wdata_q;
  uart_dbg_pkg::dbg_addr_t                   exec_addr_q;
  logic                                      tx_fire;

  assign hdr_last = (int'(hdr_cnt_q) == uart_dbg_pkg::HdrBytes - 1);
  assign len_last = (len_q == uart_dbg_pkg::dbg_len_t'(1));
  assign tx_fire  = tx_byte_o.valid && tx_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      uart_dbg_pkg::Idle: begin
        if (rx_byte_i.valid) begin
          if (rx_byte_i.data == uart_dbg_pkg::CmdRead ||
              rx_byte_i.data == uart_dbg_pkg::CmdWrite) begin
            state_d = uart_dbg_pkg::RdAddr;
          end else if (rx_byte_i.data == uart_dbg_pkg::CmdExec) begin
            state_d = uart_dbg_pkg::ExAddr;
          end else if (rx_byte_i.data == uart_dbg_pkg::DbgAck) begin
            state_d = uart_dbg_pkg::Ack;
          end
        end
      end
      uart_dbg_pkg::RdAddr: if (rx_byte_i.valid && hdr_last) state_d = uart_dbg_pkg::RdLen;
      uart_dbg_pkg::RdLen:  if (rx_byte_i.valid && hdr_last) state_d = uart_dbg_pkg::Ack;
      uart_dbg_pkg::ExAddr: if (rx_byte_i.valid && hdr_last) state_d = uart_dbg_pkg::Ack;
      uart_dbg_pkg::Ack: begin
        if (tx_fire) begin
          if (cmd_q == uart_dbg_pkg::CmdWrite) begin
            state_d = (len_q == '0) ? uart_dbg_pkg::Eot : uart_dbg_pkg::WrData;
          end else if (cmd_q == uart_dbg_pkg::CmdRead) begin
            state_d = (len_q == '0) ? uart_dbg_pkg::Eot : uart_dbg_pkg::RdFetch;
          end else begin
            state_d = uart_dbg_pkg::Idle;
          end
        end
      end
      uart_dbg_pkg::WrData: if (wr_pend_q && len_last) state_d = uart_dbg_pkg::Eot;
      uart_dbg_pkg::RdFetch: state_d = uart_dbg_pkg::RdSend;
      uart_dbg_pkg::RdSend: begin
        if (tx_fire) state_d = len_last ? uart_dbg_pkg::Eot : uart_dbg_pkg::RdFetch;
      end
      uart_dbg_pkg::Eot: if (tx_fire) state_d = uart_dbg_pkg::Idle;
      default: state_d = uart_dbg_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= uart_dbg_pkg::Idle;
      cmd_q     <= '0;
      hdr_cnt_q <= '0;
      wr_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == uart_dbg_pkg::Idle && rx_byte_i.valid) begin
        cmd_q <= rx_byte_i.data;
      end
      if (rx_byte_i.valid && state_q inside {uart_dbg_pkg::RdAddr, uart_dbg_pkg::RdLen,
                                             uart_dbg_pkg::ExAddr}) begin
        hdr_cnt_q <= hdr_last ? '0 : hdr_cnt_q + 1'b1;
      end
      // Store one cycle after the byte came in
      if (state_q == uart_dbg_pkg::WrData) begin
        if (rx_byte_i.valid) wr_pend_q <= 1'b1;
        else if (wr_pend_q) wr_pend_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Header fields and memory index
  //////////////////////////////////////////////////////////////////////

  // Little-endian fields shift in from the top
  always_ff @(posedge clk) begin
    if (rx_byte_i.valid && state_q inside {uart_dbg_pkg::RdAddr, uart_dbg_pkg::ExAddr}) begin
      addr_q <= {rx_byte_i.data, addr_q[$bits(addr_q)-1:8]};
    end
    if (rx_byte_i.valid && state_q == uart_dbg_pkg::ExAddr && hdr_last) begin
      exec_addr_q <= {rx_byte_i.data, addr_q[$bits(addr_q)-1:8]};
    end
    if (rx_byte_i.valid && state_q == uart_dbg_pkg::RdLen) begin
      len_q <= {rx_byte_i.data, len_q[$bits(len_q)-1:8]};
    end
    if (state_q == uart_dbg_pkg::Ack) begin
      idx_q <= uart_dbg_pkg::mem_addr_t'(addr_q);
    end
    if (state_q == uart_dbg_pkg::WrData && rx_byte_i.valid) begin
      wdata_q <= rx_byte_i.data;
    end
    // Index wraps at the memory size
    if ((state_q == uart_dbg_pkg::WrData && wr_pend_q) || state_q == uart_dbg_pkg::RdFetch) begin
      idx_q <= idx_q + 1'b1;
    end
    if ((state_q == uart_dbg_pkg::WrData && wr_pend_q) ||
        (state_q == uart_dbg_pkg::RdSend && tx_fire)) begin
      len_q <= len_q - 1'b1;
    end
  end

  always_comb begin
    tx_byte_o.valid = state_q inside {uart_dbg_pkg::Ack, uart_dbg_pkg::RdSend,
                                      uart_dbg_pkg::Eot};
    if (state_q == uart_dbg_pkg::Ack) begin
      tx_byte_o.data = uart_dbg_pkg::DbgAck;
    end else if (state_q == uart_dbg_pkg::Eot) begin
      tx_byte_o.data = uart_dbg_pkg::DbgEot;
    end else begin
      tx_byte_o.data = mem_rdata_i;
    end
  end

  assign mem_req_o.valid = (state_q == uart_dbg_pkg::RdFetch) ||
                           (state_q == uart_dbg_pkg::WrData && wr_pend_q);
  assign mem_req_o.we    = (state_q == uart_dbg_pkg::WrData);
  assign mem_req_o.addr  = idx_q;
  assign mem_req_o.wdata = wdata_q;

  // Pulse with the exec ACK handed to the transmitter
  assign exec_valid_o = tx_fire && state_q == uart_dbg_pkg::Ack &&
                        cmd_q == uart_dbg_pkg::CmdExec;
  assign exec_addr_o  = exec_addr_q;

  assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_byte_o.valid && !tx_ready_i |=> $stable(tx_byte_o))
    else $error("reply byte changed under back-pressure");

  // A write stores the byte received one cycle earlier
  assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_req_o.valid && mem_req_o.we |-> $past(rx_byte_i.valid))
    else $error("memory write without a received byte");

  // Reads wait for the previous reply byte so at most one is in flight
  assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_req_o.valid && !mem_req_o.we |-> $past(tx_fire))
    else $error("memory read before the previous reply byte was accepted");

endmodule

/* source/dbg_scratch_mem.sv */
`timescale 1ns/1ns

module dbg_scratch_mem (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  uart_dbg_pkg::mem_req_t mem_req_i,
  output uart_dbg_pkg::byte_t    rdata_o
);

  uart_dbg_pkg::byte_t mem_q [uart_dbg_pkg::MemDepth];

  always_ff @(posedge clk) begin
    if (mem_req_i.valid && mem_req_i.we) begin
      mem_q[mem_req_i.addr] <= mem_req_i.wdata;
    end
  end

  // Read data one cycle after the request, held until the next read
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (mem_req_i.valid && !mem_req_i.we) begin
      rdata_o <= mem_q[mem_req_i.addr];
    end
  end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  uart_dbg_pkg::tx_byte_t tx_byte_i,
  output logic                   tx_ready_o,
  output logic                   tx_o
);

  logic                                        busy_q;
  // Stop bit, data, start bit, sent from bit 0
  logic [9:0]                                  frame_q;
  logic [$clog2(uart_dbg_pkg::ClksPerBit)-1:0] cnt_q;
  logic [3:0]                                  bits_q;
  logic                                        accept;

  assign accept = tx_byte_i.valid && !busy_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      frame_q <= '1;
      cnt_q   <= '0;
      bits_q  <= '0;
    end else if (accept) begin
      busy_q  <= 1'b1;
      frame_q <= {1'b1, tx_byte_i.data, 1'b0};
      cnt_q   <= $bits(cnt_q)'(uart_dbg_pkg::ClksPerBit - 1);
      bits_q  <= 4'd9;
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        cnt_q <= $bits(cnt_q)'(uart_dbg_pkg::ClksPerBit - 1);
        if (bits_q == '0) begin
          busy_q <= 1'b0;
        end else begin
          // Ones shift in behind, so the line idles high afterwards
          frame_q <= {1'b1, frame_q[9:1]};
          bits_q  <= bits_q - 1'b1;
        end
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign tx_ready_o = !busy_q;
  assign tx_o       = frame_q[0];

  assert property (@(posedge clk) disable iff (!rst_n_i) tx_ready_o |-> tx_o)
    else $error("tx line low while transmitter idle");

endmodule

/* source/uart_dbg_server.sv */
`timescale 1ns/1ns

module uart_dbg_server (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    uart_rx_i,
  output logic                    uart_tx_o,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o
);

  uart_dbg_pkg::rx_byte_t rx_byte;
  uart_dbg_pkg::mem_req_t mem_req;
  uart_dbg_pkg::byte_t    rdata;
  uart_dbg_pkg::tx_byte_t tx_byte;
  logic                   tx_ready;

  uart_rx i_uart_rx (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .rx_i      ( uart_rx_i ),
    .rx_byte_o ( rx_byte   )
  );

  dbg_cmd_fsm i_dbg_cmd_fsm (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_byte_i    ( rx_byte      ),
    .mem_req_o    ( mem_req      ),
    .mem_rdata_i  ( rdata        ),
    .tx_byte_o    ( tx_byte      ),
    .tx_ready_i   ( tx_ready     ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  dbg_scratch_mem i_dbg_scratch_mem (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n_i ),
    .mem_req_i ( mem_req ),
    .rdata_o   ( rdata   )
  );

  uart_tx i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

endmodule

/* dv/tb_uart_dbg_server.sv */
`timescale 1ns/1ns

module tb_uart_dbg_server;

  localparam int unsigned BitClks = uart_dbg_pkg::ClksPerBit;
  // Frames per test: ack 2, write16 35, read16 35, write4 23, read2 21, exec 10, unknown 3
  localparam int unsigned Frames  = 2 + 35 + 35 + 23 + 21 + 10 + 3;
  localparam int unsigned Timeout = Frames * 11 * BitClks + 2000;

  logic                    clk;
  logic                    rst_n_i;
  logic                    uart_rx_i;
  logic                    uart_tx_o;
  logic                    exec_valid_o;
  uart_dbg_pkg::dbg_addr_t exec_addr_o;

  uart_dbg_pkg::byte_t     rx_q [$];
  uart_dbg_pkg::byte_t     ref_mem [uart_dbg_pkg::MemDepth];
  uart_dbg_pkg::dbg_addr_t exec_addr_exp;
  logic [31:0]             lfsr_q;
  int unsigned             exec_pulses;
  int unsigned             cycles;

  uart_dbg_server i_uart_dbg_server (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic uart_dbg_pkg::byte_t rand_byte();
    uart_dbg_pkg::byte_t b;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b[i]   = lfsr_q[0];
    end
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Serial line tasks
  //////////////////////////////////////////////////////////////////////

  // Start, 8 data bits LSB first, stop, then one idle bit
  task automatic send_byte(input uart_dbg_pkg::byte_t b);
    logic [10:0] frame;
    frame = {2'b11, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      uart_rx_i = frame[i];
      repeat (BitClks) @(posedge clk);
      #1;
    end
  endtask

  task automatic recv_byte(output uart_dbg_pkg::byte_t b);
    @(negedge uart_tx_o);
    repeat (BitClks / 2) @(negedge clk);
    assert (uart_tx_o == 1'b0)
      else abort_run($sformatf("FAILED %0t: start bit not low at mid-bit", $time));
    for (int i = 0; i < 8; i++) begin
      repeat (BitClks) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (BitClks) @(negedge clk);
    assert (uart_tx_o == 1'b1)
      else abort_run($sformatf("FAILED %0t: stop bit low on uart_tx_o", $time));
  endtask

  task automatic expect_byte(input uart_dbg_pkg::byte_t exp, input string what);
    uart_dbg_pkg::byte_t got;
    while (rx_q.size() == 0) begin
      @(posedge clk);
      #1;
    end
    got = rx_q.pop_front();
    assert (got == exp)
      else abort_run($sformatf("FAILED %0t: %s got 0x%02h, expected 0x%02h",
                               $time, what, got, exp));
  endtask

  // Line idle and no exec pulse for a number of bit periods
  task automatic check_quiet(input int unsigned nbits);
    repeat (nbits * BitClks) begin
      @(negedge clk);
      assert (uart_tx_o === 1'b1)
        else abort_run($sformatf("FAILED %0t: uart_tx_o not idle high", $time));
      assert (exec_valid_o === 1'b0)
        else abort_run($sformatf("FAILED %0t: unexpected exec_valid_o", $time));
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_header(input uart_dbg_pkg::byte_t cmd, input uart_dbg_pkg::dbg_addr_t addr,
                             input uart_dbg_pkg::dbg_len_t len, input bit with_len);
    send_byte(cmd);
    for (int i = 0; i < uart_dbg_pkg::HdrBytes; i++) begin
      send_byte(addr[8*i +: 8]);
    end
    if (with_len) begin
      for (int i = 0; i < uart_dbg_pkg::HdrBytes; i++) begin
        send_byte(len[8*i +: 8]);
      end
    end
  endtask

  task automatic write_mem(input uart_dbg_pkg::dbg_addr_t addr, input int unsigned n);
    uart_dbg_pkg::byte_t b;
    send_header(uart_dbg_pkg::CmdWrite, addr, n, 1'b1);
    expect_byte(uart_dbg_pkg::DbgAck, "write ACK");
    for (int unsigned i = 0; i < n; i++) begin
      b = rand_byte();
      ref_mem[(addr + i) % uart_dbg_pkg::MemDepth] = b;
      send_byte(b);
    end
    expect_byte(uart_dbg_pkg::DbgEot, "write EOT");
  endtask

  task automatic read_mem(input uart_dbg_pkg::dbg_addr_t addr, input int unsigned n);
    send_header(uart_dbg_pkg::CmdRead, addr, n, 1'b1);
    expect_byte(uart_dbg_pkg::DbgAck, "read ACK");
    for (int unsigned i = 0; i < n; i++) begin
      expect_byte(ref_mem[(addr + i) % uart_dbg_pkg::MemDepth], "read data");
    end
    expect_byte(uart_dbg_pkg::DbgEot, "read EOT");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors and checks running in the background
  //////////////////////////////////////////////////////////////////////

  initial begin
    uart_dbg_pkg::byte_t got;
    wait (rst_n_i === 1'b1);
    forever begin
      recv_byte(got);
      rx_q.push_back(got);
    end
  end

  always @(negedge clk) begin
    if (rst_n_i && exec_valid_o) begin
      exec_pulses++;
      assert (exec_addr_o == exec_addr_exp)
        else abort_run($sformatf("FAILED %0t: exec_addr_o 0x%016h, expected 0x%016h",
                                 $time, exec_addr_o, exec_addr_exp));
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i) exec_valid_o |=> !exec_valid_o)
    else abort_run($sformatf("FAILED %0t: exec_valid_o high for two cycles", $time));

  always @(posedge clk) begin
    cycles++;
    if (cycles >= Timeout) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", Timeout));
    end
  end

  initial begin
    uart_dbg_pkg::dbg_addr_t a;
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    uart_rx_i     = 1'b1;
    lfsr_q        = 32'h1811;
    exec_addr_exp = '0;
    exec_pulses   = 0;
    cycles        = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    check_quiet(20);

    send_byte(uart_dbg_pkg::DbgAck);
    expect_byte(uart_dbg_pkg::DbgAck, "ACK challenge");
    check_quiet(12);
    assert (rx_q.size() == 0)
      else abort_run($sformatf("FAILED %0t: extra reply to ACK challenge", $time));

    write_mem(64'h40, 16);
    read_mem(64'h40, 16);

    // Index 0xFE, 0xFF, then wraps to 0x00 and 0x01
    write_mem(64'hFE, 4);
    read_mem(64'h00, 2);

    for (int i = 0; i < 8; i++) begin
      a = {rand_byte(), a[63:8]};
    end
    exec_addr_exp = a;
    send_header(uart_dbg_pkg::CmdExec, a, '0, 1'b0);
    expect_byte(uart_dbg_pkg::DbgAck, "exec ACK");
    assert (exec_pulses == 1)
      else abort_run($sformatf("FAILED %0t: %0d exec pulses, expected 1", $time, exec_pulses));

    send_byte(8'h55);
    check_quiet(30);
    assert (rx_q.size() == 0)
      else abort_run($sformatf("FAILED %0t: reply to unknown command", $time));
    send_byte(uart_dbg_pkg::DbgAck);
    expect_byte(uart_dbg_pkg::DbgAck, "ACK after unknown command");

    $display(">>> PASS");
    $finish;
  end

endmodule

/* compile.f */
source/uart_dbg_pkg.sv
source/uart_rx.sv
source/dbg_cmd_fsm.sv
source/dbg_scratch_mem.sv
source/uart_tx.sv
source/uart_dbg_server.sv
dv/tb_uart_dbg_server.sv

/* Bender.yml */
package:
  name: uart_dbg_server

sources:
  - files:
      - source/uart_dbg_pkg.sv
      - source/uart_rx.sv
      - source/dbg_cmd_fsm.sv
      - source/dbg_scratch_mem.sv
      - source/uart_tx.sv
      - source/uart_dbg_server.sv
  - target: test
    files:
      - dv/tb_uart_dbg_server.sv
